//--- include/vsb_consts.svh
////////////////////////////////////////////////////////////////////////////
// Vector store buffer sizing constants
// Lane count, bank geometry, bus and counter widths
////////////////////////////////////////////////////////////////////////////
`ifndef VSB_CONSTS_SVH
`define VSB_CONSTS_SVH

// Lane organisation
`define VSB_LANES     4     // Vector lanes, one bank each
`define VSB_LANE_LOG  2     // log2 of lane count

// VLENB up to 32 bytes, multiple of 16
`define VSB_VLENB_W   6

// Per-lane bank geometry
`define VSB_DEPTH     16    // Words per bank
`define VSB_BADDR_W   4     // Bank word address

// Bus widths
`define VSB_WORD_W    32    // Data word
`define VSB_ADDR_W    32    // Byte address on memory side

// Up to 256 elements (VLENB 32, LMUL 8, SEW 8)
`define VSB_CNT_W     9

`endif

//--- hw/vsb_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Vector store buffer types
// Element width, addressing mode, drain FSM states, store configuration
////////////////////////////////////////////////////////////////////////////
`include "vsb_consts.svh"

package vsb_pkg;

  // Encoding equals log2 of element size in bytes
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_e;

  typedef enum logic {
    UNIT    = 1'b0,   // Consecutive elements
    STRIDED = 1'b1    // Fixed byte stride
  } store_mode_e;

  // Drain FSM
  typedef enum logic [2:0] {
    IDLE    = 3'd0,   // Wait for banks to fill
    READ    = 3'd1,   // Issue bank read for next element
    WAIT_RD = 3'd2,   // Bank data arriving
    REQ     = 3'd3,   // Memory request held
    REL     = 3'd4,   // Wait for ack release
    DONE    = 3'd5
  } drain_state_e;

  // Latched at cfg load, read by drain
  typedef struct packed {
    sew_e                   sew;
    store_mode_e            mode;
    logic [`VSB_CNT_W-1:0]  nelem;    // Element count
    logic [`VSB_ADDR_W-1:0] base;     // Byte address of element 0
    logic [`VSB_ADDR_W-1:0] stride;   // Byte stride, strided mode only
  } store_cfg_t;

endpackage

//--- hw/vsb_buf_if.sv
////////////////////////////////////////////////////////////////////////////
// Bank write and bank read interfaces
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "vsb_consts.svh"

// Packer to lane banks, plus fill status towards the drain
interface buf_wr_if;
  logic                                   we;         // One write per high clock
  logic [`VSB_BADDR_W-1:0]                waddr;      // Shared by all lanes
  logic [`VSB_LANES-1:0][`VSB_WORD_W-1:0] wdata;      // Element already in its byte slot
  logic [`VSB_LANES-1:0][3:0]             be;         // Byte enables per lane
  logic                                   fill_done;  // Level, all writes taken

  modport producer (
    output we, waddr, wdata, be, fill_done
  );

  modport consumer (
    input  we, waddr, wdata, be
  );

  // Drain only looks at the fill status
  modport monitor (
    input  fill_done
  );
endinterface

// Drain to lane banks, data back one clock after re
interface buf_rd_if;
  logic                                   re;
  logic [`VSB_BADDR_W-1:0]                raddr;
  logic [`VSB_WORD_W-1:0]                 rdata [`VSB_LANES];  // One word per lane

  modport requester (
    output re, raddr,
    input  rdata
  );

  // Each bank drives its own rdata entry
  modport memory (
    input  re, raddr,
    output rdata
  );
endinterface

//--- hw/vsb_lane_packer.sv
////////////////////////////////////////////////////////////////////////////
// Lane packer: config latch, element count, lane write handshake
// Packs narrow elements into byte slots of the per-lane bank words
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "vsb_consts.svh"

module vsb_lane_packer
  import vsb_pkg::*;
(
  input  logic                                   clk,
  input  logic                                   rstn,
  // Configuration
  input  logic                                   cfg_load_i,
  input  logic [`VSB_VLENB_W-1:0]                cfg_vlenb_i,
  input  logic [1:0]                             cfg_lmul_i,    // log2 LMUL
  input  sew_e                                   cfg_sew_i,
  input  store_mode_e                            cfg_mode_i,
  input  logic [`VSB_ADDR_W-1:0]                 cfg_base_i,
  input  logic [`VSB_ADDR_W-1:0]                 cfg_stride_i,
  // Lane write, four-phase
  input  logic                                   wr_req_i,
  input  logic [`VSB_LANES-1:0][`VSB_WORD_W-1:0] lane_data_i,
  output logic                                   wr_ack_o,
  // Bank side
  buf_wr_if.producer                             bw,
  output store_cfg_t                             cfg_o
);

  localparam int CW = `VSB_CNT_W;

  logic [CW-1:0] byte_total;   // VLENB scaled by LMUL
  logic [CW-1:0] elem_total;   // From live config inputs
  logic [CW-1:0] wr_total;     // From latched config
  logic [CW-1:0] wr_cnt_q;     // Accepted lane writes
  logic          ack_q;
  logic          fill_q;
  logic          take;         // Bank write this clock
  logic [1:0]    slot;         // Byte slot inside lane word
  logic [3:0]    be_mask;
  store_cfg_t    cfg_q;

  assign byte_total = CW'(cfg_vlenb_i) << cfg_lmul_i;
  assign elem_total = byte_total >> cfg_sew_i;      // Divide by element bytes
  assign wr_total   = cfg_q.nelem >> `VSB_LANE_LOG;  // One element per lane per write

  // New request, not yet acked, room left; cfg load cycle never writes
  assign take = wr_req_i && !ack_q && !cfg_load_i && (wr_cnt_q < wr_total);

  ////////////////////////////////////////////////////////////////////////////
  // Slot and word address from write count
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    case (cfg_q.sew)
      SEW32: begin
        slot     = 2'd0;
        be_mask  = 4'b1111;
        bw.waddr = wr_cnt_q[`VSB_BADDR_W-1:0];
      end
      SEW16: begin
        slot     = {wr_cnt_q[0], 1'b0};         // Half 0 or 1
        be_mask  = 4'b0011 << slot;
        bw.waddr = wr_cnt_q[`VSB_BADDR_W:1];
      end
      default: begin                            // SEW8, four writes per word
        slot     = wr_cnt_q[1:0];
        be_mask  = 4'b0001 << slot;
        bw.waddr = wr_cnt_q[`VSB_BADDR_W+1:2];
      end
    endcase
  end

  // Low element bits shifted up to the slot, enables mask the rest
  always_comb begin
    for (int l = 0; l < `VSB_LANES; l++) begin
      bw.wdata[l] = lane_data_i[l] << {slot, 3'b000};
      bw.be[l]    = be_mask;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Config latch, write count, fill status
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      cfg_q    <= '0;
      wr_cnt_q <= '0;
      fill_q   <= 1'b0;
    end else if (cfg_load_i) begin
      cfg_q    <= '{sew: cfg_sew_i, mode: cfg_mode_i, nelem: elem_total,
                    base: cfg_base_i, stride: cfg_stride_i};
      wr_cnt_q <= '0;
      fill_q   <= 1'b0;
    end else if (take) begin
      wr_cnt_q <= wr_cnt_q + 1'b1;
      if (wr_cnt_q == wr_total - 1'b1)
        fill_q <= 1'b1;                         // Last write lands this edge
    end
  end

  // Ack rises with the bank write, falls once req is seen low
  always_ff @(posedge clk) begin
    if (!rstn)
      ack_q <= 1'b0;
    else if (take)
      ack_q <= 1'b1;
    else if (!wr_req_i)
      ack_q <= 1'b0;
  end

  assign wr_ack_o     = ack_q;
  assign bw.we        = take;
  assign bw.fill_done = fill_q;
  assign cfg_o        = cfg_q;

endmodule

//--- hw/vsb_lane_bank.sv
////////////////////////////////////////////////////////////////////////////
// Lane bank: simple dual-port word memory with byte write enables
// and a registered read port
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "vsb_consts.svh"

module vsb_lane_bank #(
  parameter int LANE = 0                  // Which lane this bank serves
) (
  input  logic         clk,
  input  logic         rstn,
  buf_wr_if.consumer   bw,
  buf_rd_if.memory     br
);

  logic [`VSB_WORD_W-1:0] mem [`VSB_DEPTH];
  logic [`VSB_WORD_W-1:0] rd_q;           // Read output register

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (bw.we) begin
      for (int b = 0; b < 4; b++) begin
        if (bw.be[LANE][b])
          mem[bw.waddr][b*8 +: 8] <= bw.wdata[LANE][b*8 +: 8];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read port, data one clock after re
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn)
      rd_q <= '0;
    else if (br.re)
      rd_q <= mem[br.raddr];
  end

  assign br.rdata[LANE] = rd_q;           // Own lane entry only

endmodule

//--- hw/vsb_store_drain.sv
////////////////////////////////////////////////////////////////////////////
// Store drain: walks the stored elements, reads the lane banks and
// issues aligned 32-bit memory writes with rotated data and strobes
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "vsb_consts.svh"

module vsb_store_drain
  import vsb_pkg::*;
(
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   cfg_load_i,
  input  store_cfg_t             cfg_i,
  buf_wr_if.monitor              bw_status,
  buf_rd_if.requester            br,
  // Memory write, four-phase
  output logic                   mem_req_o,
  output logic [`VSB_ADDR_W-1:0] mem_addr_o,
  output logic [`VSB_WORD_W-1:0] mem_wdata_o,
  output logic [3:0]             mem_strb_o,
  input  logic                   mem_ack_i,
  output logic                   store_done_o
);

  localparam int CW = `VSB_CNT_W;

  drain_state_e             state_q, state_d;
  logic [CW-1:0]            elem_q;      // Current element index
  logic [CW-1:0]            word_idx;    // Element position within its lane
  logic [`VSB_LANE_LOG-1:0] lane;
  logic [`VSB_ADDR_W-1:0]   addr_q;      // Byte address of current element
  logic [`VSB_ADDR_W-1:0]   step;
  logic [2:0]               sew_bytes;
  logic [3:0]               sew_mask;
  logic [1:0]               slot;        // Byte slot in bank word
  logic [`VSB_WORD_W-1:0]   data_mask;
  logic [`VSB_WORD_W-1:0]   elem_val;    // Element at bit 0
  logic [`VSB_WORD_W-1:0]   elem_rot;    // Element at address byte offset
  logic                     last_elem;
  logic                     req_q, done_q;
  logic [`VSB_ADDR_W-1:0]   maddr_q;
  logic [`VSB_WORD_W-1:0]   wdata_q;
  logic [3:0]               strb_q;

  assign lane      = elem_q[`VSB_LANE_LOG-1:0];      // Lane l owns elements l, l+4, ...
  assign word_idx  = elem_q >> `VSB_LANE_LOG;
  assign last_elem = (elem_q == cfg_i.nelem - 1'b1);
  assign step      = (cfg_i.mode == STRIDED) ? cfg_i.stride : `VSB_ADDR_W'(sew_bytes);

  ////////////////////////////////////////////////////////////////////////////
  // Bank address, slot and masks by element width
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    case (cfg_i.sew)
      SEW32: begin
        br.raddr = word_idx[`VSB_BADDR_W-1:0];
        slot = 2'd0;  sew_bytes = 3'd4;  sew_mask = 4'b1111;
        data_mask = 32'hffff_ffff;
      end
      SEW16: begin
        br.raddr = word_idx[`VSB_BADDR_W:1];
        slot = {word_idx[0], 1'b0};  sew_bytes = 3'd2;  sew_mask = 4'b0011;
        data_mask = 32'h0000_ffff;
      end
      default: begin                                   // SEW8
        br.raddr = word_idx[`VSB_BADDR_W+1:2];
        slot = word_idx[1:0];  sew_bytes = 3'd1;  sew_mask = 4'b0001;
        data_mask = 32'h0000_00ff;
      end
    endcase
  end

  // Pull element down from its slot, then rotate up to the address offset
  assign elem_val = (br.rdata[lane] >> {slot, 3'b000}) & data_mask;
  always_comb begin
    case (addr_q[1:0])
      2'd1:    elem_rot = {elem_val[23:0], elem_val[31:24]};
      2'd2:    elem_rot = {elem_val[15:0], elem_val[31:16]};
      2'd3:    elem_rot = {elem_val[7:0],  elem_val[31:8]};
      default: elem_rot = elem_val;
    endcase
  end

  // First read goes out straight from IDLE, index already zero
  assign br.re = (state_q == READ) || (state_q == IDLE && bw_status.fill_done);

  ////////////////////////////////////////////////////////////////////////////
  // Drain FSM
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (bw_status.fill_done) state_d = WAIT_RD;
      READ:    state_d = WAIT_RD;
      WAIT_RD: state_d = REQ;                          // Bank data valid here
      REQ:     if (mem_ack_i) state_d = REL;
      REL:     if (!mem_ack_i) state_d = last_elem ? DONE : READ;
      DONE:    state_d = DONE;                         // Until next cfg load
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn || cfg_load_i) begin
      state_q <= IDLE;
      elem_q  <= '0;
      req_q   <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == WAIT_RD)
        req_q <= 1'b1;
      else if (state_q == REQ && mem_ack_i)
        req_q <= 1'b0;
      if (state_q == REL && !mem_ack_i) begin
        if (last_elem)
          done_q <= 1'b1;
        else
          elem_q <= elem_q + 1'b1;
      end
    end
  end

  // Running address, base reloaded while idle
  always_ff @(posedge clk) begin
    if (state_q == IDLE)
      addr_q <= cfg_i.base;
    else if (state_q == REL && !mem_ack_i)
      addr_q <= addr_q + step;
  end

  // Request payload, held through the handshake
  always_ff @(posedge clk) begin
    if (state_q == WAIT_RD) begin
      maddr_q <= {addr_q[`VSB_ADDR_W-1:2], 2'b00};     // Word aligned
      wdata_q <= elem_rot;
      strb_q  <= sew_mask << addr_q[1:0];
    end
  end

  assign mem_req_o    = req_q;
  assign mem_addr_o   = maddr_q;
  assign mem_wdata_o  = wdata_q;
  assign mem_strb_o   = strb_q;
  assign store_done_o = done_q;

endmodule

//--- hw/vsb_top.sv
////////////////////////////////////////////////////////////////////////////
// Vector store buffer top: lane packer, per-lane banks, store drain
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "vsb_consts.svh"

module vsb_top
  import vsb_pkg::*;
(
  input  logic                                   clk,
  input  logic                                   rstn,
  // Configuration
  input  logic                                   cfg_load_i,
  input  logic [`VSB_VLENB_W-1:0]                cfg_vlenb_i,
  input  logic [1:0]                             cfg_lmul_i,
  input  sew_e                                   cfg_sew_i,
  input  store_mode_e                            cfg_mode_i,
  input  logic [`VSB_ADDR_W-1:0]                 cfg_base_i,
  input  logic [`VSB_ADDR_W-1:0]                 cfg_stride_i,
  // Lane write
  input  logic                                   wr_req_i,
  input  logic [`VSB_LANES-1:0][`VSB_WORD_W-1:0] lane_data_i,
  output logic                                   wr_ack_o,
  // Memory write
  output logic                                   mem_req_o,
  output logic [`VSB_ADDR_W-1:0]                 mem_addr_o,
  output logic [`VSB_WORD_W-1:0]                 mem_wdata_o,
  output logic [3:0]                             mem_strb_o,
  input  logic                                   mem_ack_i,
  // Status
  output logic                                   store_done_o
);

  buf_wr_if   bw_if ();
  buf_rd_if   br_if ();
  store_cfg_t cfg;                // Latched config, packer to drain

  vsb_lane_packer u_packer (
    .clk          (clk),
    .rstn         (rstn),
    .cfg_load_i   (cfg_load_i),
    .cfg_vlenb_i  (cfg_vlenb_i),
    .cfg_lmul_i   (cfg_lmul_i),
    .cfg_sew_i    (cfg_sew_i),
    .cfg_mode_i   (cfg_mode_i),
    .cfg_base_i   (cfg_base_i),
    .cfg_stride_i (cfg_stride_i),
    .wr_req_i     (wr_req_i),
    .lane_data_i  (lane_data_i),
    .wr_ack_o     (wr_ack_o),
    .bw           (bw_if.producer),
    .cfg_o        (cfg)
  );

  // One bank per lane
  for (genvar l = 0; l < `VSB_LANES; l++) begin : g_bank
    vsb_lane_bank #(.LANE(l)) u_bank (
      .clk  (clk),
      .rstn (rstn),
      .bw   (bw_if.consumer),
      .br   (br_if.memory)
    );
  end

  vsb_store_drain u_drain (
    .clk          (clk),
    .rstn         (rstn),
    .cfg_load_i   (cfg_load_i),
    .cfg_i        (cfg),
    .bw_status    (bw_if.monitor),
    .br           (br_if.requester),
    .mem_req_o    (mem_req_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_strb_o   (mem_strb_o),
    .mem_ack_i    (mem_ack_i),
    .store_done_o (store_done_o)
  );

endmodule

//--- dv/vsb_chk.sv
////////////////////////////////////////////////////////////////////////////
// Handshake and reset assertions bound to the vector store buffer top
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "vsb_consts.svh"

module vsb_chk (
  input logic                   clk,
  input logic                   rstn,
  input logic                   wr_req_i,
  input logic                   wr_ack_i,
  input logic                   mem_req_i,
  input logic                   mem_ack_i,
  input logic [`VSB_ADDR_W-1:0] mem_addr_i,
  input logic [`VSB_WORD_W-1:0] mem_wdata_i,
  input logic [3:0]             mem_strb_i,
  input logic                   store_done_i
);

  int unsigned fail_cnt = 0;    // Violations so far

  // Ack answers a request seen on the previous edge
  a_ack_after_req: assert property (@(posedge clk) disable iff (!rstn)
    $rose(wr_ack_i) |-> $past(wr_req_i))
    else begin $error("wr_ack rose without wr_req"); fail_cnt++; end

  a_req_hold: assert property (@(posedge clk) disable iff (!rstn)
    mem_req_i && !mem_ack_i |=> mem_req_i)          // No withdraw before ack
    else begin $error("mem_req dropped before mem_ack"); fail_cnt++; end

  a_payload_stable: assert property (@(posedge clk) disable iff (!rstn)
    mem_req_i && !mem_ack_i |=>
      $stable(mem_addr_i) && $stable(mem_wdata_i) && $stable(mem_strb_i))
    else begin $error("mem payload changed while waiting"); fail_cnt++; end

  a_strb_nonzero: assert property (@(posedge clk) disable iff (!rstn)
    mem_req_i |-> mem_strb_i != 4'b0000)
    else begin $error("mem_strb zero during request"); fail_cnt++; end

  // Synchronous reset clears control outputs on the next edge
  a_reset_low: assert property (@(posedge clk)
    !rstn |=> !wr_ack_i && !mem_req_i && !store_done_i)
    else begin $error("control output high after reset"); fail_cnt++; end

endmodule

bind vsb_top vsb_chk u_chk (
  .clk          (clk),
  .rstn         (rstn),
  .wr_req_i     (wr_req_i),
  .wr_ack_i     (wr_ack_o),
  .mem_req_i    (mem_req_o),
  .mem_ack_i    (mem_ack_i),
  .mem_addr_i   (mem_addr_o),
  .mem_wdata_i  (mem_wdata_o),
  .mem_strb_i   (mem_strb_o),
  .store_done_i (store_done_o)
);

//--- dv/vsb_tb.sv
////////////////////////////////////////////////////////////////////////////
// Vector store buffer testbench with clock, reset and LFSR stimulus
// Memory responder checks each request against the reference model
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "vsb_consts.svh"

module vsb_tb
  import vsb_pkg::*;
();

  localparam int TOTAL_ELEMS   = 168;   // 4 + 32 + 128 + 4
  localparam int TOTAL_WRITES  = 42;    // 1 + 8 + 32 + 1
  localparam int ACK_DELAY_MAX = 8;     // 3 random bits plus handshake edge
  localparam int WATCHDOG_CYCLES = (TOTAL_ELEMS + TOTAL_WRITES) * 40 * ACK_DELAY_MAX;

  logic clk, rstn, cfg_load_i, wr_req_i, wr_ack_o;
  logic [`VSB_VLENB_W-1:0] cfg_vlenb_i;
  logic [1:0] cfg_lmul_i;
  sew_e cfg_sew_i;
  store_mode_e cfg_mode_i;
  logic [`VSB_ADDR_W-1:0] cfg_base_i, cfg_stride_i, mem_addr_o;
  logic [`VSB_LANES-1:0][`VSB_WORD_W-1:0] lane_data_i;
  logic mem_req_o, mem_ack_i, store_done_o;
  logic [`VSB_WORD_W-1:0] mem_wdata_o;
  logic [3:0] mem_strb_o;

  logic [31:0] lfsr = 32'hb3a9;
  logic [31:0] elems [256];             // Written elements by element number
  logic [31:0] cur_base, step_bytes;
  int          sew_bytes, n_elem, mem_seen;
  logic        rand_ack;                // Random ack delay on/off

  vsb_top dut0 (.*);

  initial begin : clock_gen
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////
  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else stop_run($sformatf("FAIL %s exp %h got %h", name, exp, got));
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);   // x^32+x^22+x^2+x+1
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  function automatic int sew_size(input sew_e sew);
    case (sew)
      SEW8:    return 1;
      SEW16:   return 2;
      default: return 4;
    endcase
  endfunction

  task automatic check_reset_outputs();
    expect_eq("wr_ack_o", 32'h0, wr_ack_o);
    expect_eq("mem_req_o", 32'h0, mem_req_o);
    expect_eq("store_done_o", 32'h0, store_done_o);
  endtask

  task automatic load_cfg(input logic [5:0] vlenb, input logic [1:0] lmul, input sew_e sew,
                          input store_mode_e mode, input logic [31:0] base, stride);
    @(negedge clk);
    cfg_vlenb_i  = vlenb;
    cfg_lmul_i   = lmul;
    cfg_sew_i    = sew;
    cfg_mode_i   = mode;
    cfg_base_i   = base;
    cfg_stride_i = stride;
    cfg_load_i   = 1'b1;
    sew_bytes    = sew_size(sew);
    n_elem       = (int'(vlenb) << lmul) / sew_bytes;    // N from VLENB, LMUL, SEW
    step_bytes   = (mode == STRIDED) ? stride : 32'(sew_bytes);
    cur_base     = base;
    mem_seen     = 0;
    @(negedge clk);
    cfg_load_i   = 1'b0;
    assert (!store_done_o) else stop_run("store_done_o still high after cfg_load_i");
  endtask

  // Four-phase lane write with element w*LANES+l on lane l
  task automatic lane_write(input int w);
    logic [31:0] d, mask;
    mask = (sew_bytes == 4) ? 32'hffff_ffff : (32'h1 << (8 * sew_bytes)) - 1;
    for (int l = 0; l < `VSB_LANES; l++) begin
      d = rand_bits(32);
      lane_data_i[l] = d;
      elems[w * `VSB_LANES + l] = d & mask;
    end
    wr_req_i = 1'b1;
    do @(negedge clk); while (!wr_ack_o);
    wr_req_i = 1'b0;
    do @(negedge clk); while (wr_ack_o);
  endtask

  // Expected address, strobe and data from the element rules
  task automatic check_request();
    logic [31:0] a, exp_data, bmask;
    assert (mem_seen < n_elem) else stop_run("Memory write beyond the element count");
    a        = cur_base + mem_seen * step_bytes;
    exp_data = elems[mem_seen] << (8 * a[1:0]);
    for (int b = 0; b < 4; b++)
      bmask[b*8 +: 8] = {8{mem_strb_o[b]}};
    expect_eq("mem_addr_o", {a[31:2], 2'b00}, mem_addr_o);
    expect_eq("mem_strb_o", ((1 << sew_bytes) - 1) << a[1:0], mem_strb_o);
    expect_eq("mem_wdata_o", exp_data, mem_wdata_o & bmask);
    mem_seen++;
  endtask

  task automatic run_store(input logic [5:0] vlenb, input logic [1:0] lmul, input sew_e sew,
                           input store_mode_e mode, input logic [31:0] base, stride,
                           input logic rnd_ack, extra_req);
    load_cfg(vlenb, lmul, sew, mode, base, stride);
    rand_ack = rnd_ack;
    for (int w = 0; w < n_elem / `VSB_LANES; w++)
      lane_write(w);
    wr_req_i = extra_req;                        // Surplus write that must stay unacked
    do begin
      @(negedge clk);
      assert (!wr_ack_o) else stop_run("Lane write acknowledged after the last one");
    end while (!store_done_o);
    wr_req_i = 1'b0;
    expect_eq("mem_req_o count", n_elem, mem_seen);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory responder checks each request then acks after a delay
  ////////////////////////////////////////////////////////////////////////////
  initial begin : mem_responder
    int unsigned delay;
    forever begin
      @(negedge clk);
      if (mem_req_o && !mem_ack_i) begin
        check_request();
        delay = rand_ack ? rand_bits(3) : 0;
        repeat (delay) @(negedge clk);
        mem_ack_i = 1'b1;
        do @(negedge clk); while (mem_req_o);
        mem_ack_i = 1'b0;
      end
    end
  end

  initial begin : chk_monitor
    wait (dut0.u_chk.fail_cnt != 0);
    stop_run("Bound checker flagged a handshake or reset violation");
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_run("Watchdog expired before all stores drained");
  end

  initial begin : main
    rstn         = 1'b0;
    cfg_load_i   = 1'b0;
    wr_req_i     = 1'b0;
    mem_ack_i    = 1'b0;
    cfg_vlenb_i  = '0;
    cfg_lmul_i   = '0;
    cfg_sew_i    = SEW8;
    cfg_mode_i   = UNIT;
    cfg_base_i   = '0;
    cfg_stride_i = '0;
    lane_data_i  = '0;
    rand_ack     = 1'b0;
    repeat (5) begin
      @(negedge clk);
      check_reset_outputs();
    end
    rstn = 1'b1;
    repeat (2) begin
      @(negedge clk);
      check_reset_outputs();
    end
    run_store(6'd16, 2'd0, SEW32, UNIT,    32'h0000_2000, 32'h0,  1'b0, 1'b0);
    run_store(6'd16, 2'd1, SEW8,  STRIDED, 32'h0000_1003, 32'h5,  1'b0, 1'b0);
    run_store(6'd32, 2'd3, SEW16, UNIT,    32'h0000_4002, 32'h0,  1'b1, 1'b1);  // Full bank
    run_store(6'd16, 2'd0, SEW32, STRIDED, 32'h0000_8000, 32'h10, 1'b1, 1'b0);  // Reload
    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- all.f
+incdir+include
hw/vsb_pkg.sv
hw/vsb_buf_if.sv
hw/vsb_lane_packer.sv
hw/vsb_lane_bank.sv
hw/vsb_store_drain.sv
hw/vsb_top.sv
dv/vsb_chk.sv
dv/vsb_tb.sv

//--- Bender.yml
package:
  name: vsb

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/vsb_pkg.sv
      - hw/vsb_buf_if.sv
      - hw/vsb_lane_packer.sv
      - hw/vsb_lane_bank.sv
      - hw/vsb_store_drain.sv
      - hw/vsb_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/vsb_chk.sv
      - dv/vsb_tb.sv
